// ==== wb_bridge_pkg.sv ====
// Wishbone bridge shared definitions
package wb_bridge_pkg;

  // ====================
  // Bus and line geometry
  // ====================
  localparam int WB_ADDR_WIDTH = 32;  // Byte address
  localparam int WB_DATA_WIDTH = 32;  // One bus word
  localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;
  localparam int BLK_SIZE      = 128;  // Cache line in bits
  localparam int BURST_LEN     = BLK_SIZE / WB_DATA_WIDTH;  // 4 beats per line
  localparam int ID_WIDTH      = 4;

  // Access size of an uncached request
  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } rw_size_e;

  // ====================
  // Cycle and burst tags
  // ====================
  localparam logic [2:0] WB_CTI_CLASSIC = 3'b000;
  localparam logic [2:0] WB_CTI_INCR    = 3'b010;  // Incrementing beat
  localparam logic [2:0] WB_CTI_EOB     = 3'b111;  // Last beat of burst

  localparam logic [1:0] WB_BTE_LINEAR = 2'b00;
  localparam logic [1:0] WB_BTE_WRAP4  = 2'b01;

  // ====================
  // Address map
  // ====================
  localparam logic [3:0] RAM_REGION    = 4'h0;  // Upper nibble
  localparam logic [3:0] PERIPH_REGION = 4'h2;

  localparam logic [WB_DATA_WIDTH-1:0] PERIPH_ID = 32'h5742_0b41;  // Read at offset 0x10

  // Lane enables for a sub-word access
  function automatic logic [WB_SEL_WIDTH-1:0] gen_byte_sel(
    input rw_size_e                 size,
    input logic [WB_ADDR_WIDTH-1:0] addr
  );
    logic [WB_SEL_WIDTH-1:0] sel;
    case (size)
      BYTE:    sel = WB_SEL_WIDTH'(1) << addr[1:0];  // One lane
      HALF:    sel = addr[1] ? 4'b1100 : 4'b0011;    // Upper or lower half
      default: sel = '1;
    endcase
    return sel;
  endfunction

endpackage

// ==== wb_master_bridge.sv ====
// Wishbone B4 master bridge
module wb_master_bridge import wb_bridge_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Request port
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  logic                     req_rw_i,  // 1 = write
  input  logic                     req_uncached_i,
  input  rw_size_e                 req_size_i,
  input  logic [WB_ADDR_WIDTH-1:0] req_addr_i,
  input  logic [BLK_SIZE-1:0]      req_data_i,
  input  logic [ID_WIDTH-1:0]      req_id_i,
  // Response port
  output logic                     res_valid_o,
  output logic                     res_err_o,
  output logic [ID_WIDTH-1:0]      res_id_o,
  output logic [BLK_SIZE-1:0]      res_blk_o,
  // Wishbone master side
  output logic                     wb_cyc_o,
  output logic                     wb_stb_o,
  output logic                     wb_we_o,
  output logic [WB_ADDR_WIDTH-1:0] wb_adr_o,
  output logic [WB_DATA_WIDTH-1:0] wb_dat_o,
  output logic [WB_SEL_WIDTH-1:0]  wb_sel_o,
  output logic [2:0]               wb_cti_o,
  output logic [1:0]               wb_bte_o,
  input  logic [WB_DATA_WIDTH-1:0] wb_dat_i,
  input  logic                     wb_ack_i,
  input  logic                     wb_err_i,
  input  logic                     wb_stall_i
);

  localparam int BEAT_W   = $clog2(BURST_LEN);
  localparam int LINE_OFS = $clog2(BLK_SIZE / 8);  // Byte offset bits in a line

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SINGLE_REQ,   // stb out, waiting for no stall
    ST_SINGLE_WAIT,  // Beat taken, waiting for ack or err
    ST_BURST,        // Line transfer, one beat in flight at most
    ST_ERROR         // Error response cycle
  } state_e;

  state_e state_q, state_d;

  logic [WB_ADDR_WIDTH-1:0]                  addr_q;
  logic [BURST_LEN-1:0][WB_DATA_WIDTH-1:0] wdata_q;  // Line to write, word per beat
  logic [BURST_LEN-1:0][WB_DATA_WIDTH-1:0] rdata_q;  // Beats read so far
  logic [WB_SEL_WIDTH-1:0]                   sel_q;
  logic [ID_WIDTH-1:0]                       id_q;
  logic [BEAT_W-1:0]                         beat_q;
  logic                                      pend_q;  // Burst beat issued, ack pending
  logic                                      write_q;

  logic accept;
  logic is_uncached;
  logic last_beat;

  assign accept      = req_valid_i && req_ready_o;
  // Sub-word stores cannot be merged into a line
  assign is_uncached = req_uncached_i || (req_rw_i && req_size_i != WORD);
  assign last_beat   = (beat_q == BEAT_W'(BURST_LEN - 1));

  // ====================
  // Next state
  // ====================
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) state_d = is_uncached ? ST_SINGLE_REQ : ST_BURST;
      end
      ST_SINGLE_REQ: begin
        if (!wb_stall_i) state_d = ST_SINGLE_WAIT;
      end
      ST_SINGLE_WAIT: begin
        if (wb_ack_i) state_d = ST_IDLE;
        else if (wb_err_i) state_d = ST_ERROR;
      end
      ST_BURST: begin
        if (wb_err_i) state_d = ST_ERROR;  // Abort rest of line
        else if (wb_ack_i && last_beat) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;  // Error reported, back to idle
    endcase
  end

  // Control state
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      beat_q  <= '0;
      pend_q  <= 1'b0;
      write_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        beat_q  <= '0;
        pend_q  <= 1'b0;
        write_q <= req_rw_i;
      end else if (state_q == ST_BURST) begin
        if (wb_stb_o && !wb_stall_i) begin
          pend_q <= 1'b1;
        end else if (wb_ack_i) begin
          pend_q <= 1'b0;
          beat_q <= beat_q + 1'b1;  // Address moves on after ack
        end
      end
    end
  end

  // Request payload and read line
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= req_addr_i;
      id_q   <= req_id_i;
      sel_q  <= is_uncached ? gen_byte_sel(req_size_i, req_addr_i) : '1;
      for (int i = 0; i < BURST_LEN; i++) begin
        wdata_q[i] <= req_data_i[i*WB_DATA_WIDTH +: WB_DATA_WIDTH];  // Word 0 for singles
      end
    end
    if (state_q == ST_BURST && wb_ack_i && !write_q) rdata_q[beat_q] <= wb_dat_i;
  end

  // ====================
  // Bus outputs
  // ====================
  always_comb begin
    wb_cyc_o = 1'b0;
    wb_stb_o = 1'b0;
    wb_we_o  = write_q;
    wb_adr_o = addr_q;
    wb_dat_o = wdata_q[beat_q];
    wb_sel_o = sel_q;
    wb_cti_o = WB_CTI_CLASSIC;
    wb_bte_o = WB_BTE_LINEAR;
    case (state_q)
      ST_SINGLE_REQ: begin
        wb_cyc_o = 1'b1;
        wb_stb_o = 1'b1;
      end
      ST_SINGLE_WAIT: wb_cyc_o = 1'b1;  // Hold cycle until reply
      ST_BURST: begin
        wb_cyc_o = 1'b1;
        wb_stb_o = !pend_q;
        wb_adr_o = {addr_q[WB_ADDR_WIDTH-1:LINE_OFS], beat_q, 2'b00};  // Line base + beat
        wb_cti_o = last_beat ? WB_CTI_EOB : WB_CTI_INCR;
        wb_bte_o = WB_BTE_WRAP4;
      end
      default: ;
    endcase
  end

  // Response
  assign req_ready_o = (state_q == ST_IDLE);
  assign res_err_o   = (state_q == ST_ERROR);
  assign res_id_o    = id_q;
  assign res_valid_o = (state_q == ST_SINGLE_WAIT && wb_ack_i) ||
                       (state_q == ST_BURST && wb_ack_i && last_beat) ||
                       res_err_o;

  always_comb begin
    res_blk_o = '0;  // Writes return no data
    if (!write_q) begin
      if (state_q == ST_SINGLE_WAIT) begin
        res_blk_o = {BURST_LEN{wb_dat_i}};  // Single word in every lane
      end else begin
        for (int i = 0; i < BURST_LEN; i++) begin
          // Beat arriving now bypasses the line buffer
          res_blk_o[i*WB_DATA_WIDTH +: WB_DATA_WIDTH] =
            (beat_q == BEAT_W'(i)) ? wb_dat_i : rdata_q[i];
        end
      end
    end
  end

  // Stalled beat stays on the bus unchanged
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_stb_o && wb_stall_i) |=> (wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o)))
    else $error("stalled beat changed before it was taken");

  // One request in flight, port stays closed until its response
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> (!req_ready_o until_with res_valid_o))
    else $error("request port reopened before response");

endmodule

// ==== wb_addr_decoder.sv ====
// Wishbone address decoder
module wb_addr_decoder import wb_bridge_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     cyc_i,
  input  logic                     stb_i,
  input  logic [WB_ADDR_WIDTH-1:0] adr_i,
  // RAM slave
  output logic                     ram_cyc_o,
  output logic                     ram_stb_o,
  input  logic [WB_DATA_WIDTH-1:0] ram_dat_i,
  input  logic                     ram_ack_i,
  input  logic                     ram_stall_i,
  // Peripheral slave
  output logic                     periph_cyc_o,
  output logic                     periph_stb_o,
  input  logic [WB_DATA_WIDTH-1:0] periph_dat_i,
  input  logic                     periph_ack_i,
  input  logic                     periph_err_i,
  // Muxed reply to master
  output logic [WB_DATA_WIDTH-1:0] dat_o,
  output logic                     ack_o,
  output logic                     err_o,
  output logic                     stall_o
);

  logic [3:0] region;
  logic       ram_hit, periph_hit;
  logic       unmapped_err_q;  // Decoder's own error reply

  assign region     = adr_i[WB_ADDR_WIDTH-1 -: 4];
  assign ram_hit    = (region == RAM_REGION);
  assign periph_hit = (region == PERIPH_REGION);

  assign ram_cyc_o    = cyc_i && ram_hit;
  assign ram_stb_o    = stb_i && ram_hit;
  assign periph_cyc_o = cyc_i && periph_hit;
  assign periph_stb_o = stb_i && periph_hit;

  assign dat_o   = periph_hit ? periph_dat_i : ram_dat_i;
  assign ack_o   = (ram_hit && ram_ack_i) || (periph_hit && periph_ack_i);
  assign err_o   = (periph_hit && periph_err_i) || unmapped_err_q;
  assign stall_o = ram_stb_o && ram_stall_i;  // Peripheral never stalls

  // Unmapped beats are taken at once and answered next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_ni) unmapped_err_q <= 1'b0;
    else unmapped_err_q <= cyc_i && stb_i && !ram_hit && !periph_hit;
  end

  // Only the selected target ever replies
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({ram_ack_i, periph_ack_i || periph_err_i, unmapped_err_q}))
    else $error("replies from more than one target");

endmodule

// ==== wb_ram_slave.sv ====
// Wishbone word RAM slave
module wb_ram_slave import wb_bridge_pkg::*; #(
  parameter int RAM_WORDS = 64  // Power of two
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     cyc_i,
  input  logic                     stb_i,
  input  logic                     we_i,
  input  logic [WB_ADDR_WIDTH-1:0] adr_i,
  input  logic [WB_DATA_WIDTH-1:0] dat_i,
  input  logic [WB_SEL_WIDTH-1:0]  sel_i,
  output logic [WB_DATA_WIDTH-1:0] dat_o,
  output logic                     ack_o,
  output logic                     stall_o
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  logic [WB_DATA_WIDTH-1:0] mem_q [RAM_WORDS];
  logic [IDX_W-1:0]         idx;
  logic                     active_q;  // Wait state already spent in this cycle
  logic                     ack_q;
  logic                     xfer;

  assign idx     = adr_i[IDX_W+1:2];  // Word index, aliases across region
  assign stall_o = cyc_i && stb_i && !active_q;
  assign xfer    = cyc_i && stb_i && !stall_o;
  assign ack_o   = ack_q;

  // ====================
  // Handshake
  // ====================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      active_q <= cyc_i && (active_q || stb_i);  // Cleared when cyc drops
      ack_q    <= xfer;
    end
  end

  // ====================
  // Storage
  // ====================
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      if (we_i) begin
        for (int b = 0; b < WB_SEL_WIDTH; b++) begin
          if (sel_i[b]) mem_q[idx][8*b +: 8] <= dat_i[8*b +: 8];  // Lane write
        end
      end
      dat_o <= mem_q[idx];  // Old word on a write, unused there
    end
  end

  // Master must keep the cycle open until the reply
  assert property (@(posedge clk_i) disable iff (!rst_ni) ack_o |-> cyc_i)
    else $error("RAM ack outside a bus cycle");

endmodule

// ==== wb_periph_slave.sv ====
// Peripheral register slave
module wb_periph_slave import wb_bridge_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     cyc_i,
  input  logic                     stb_i,
  input  logic                     we_i,
  input  logic [WB_ADDR_WIDTH-1:0] adr_i,
  input  logic [WB_DATA_WIDTH-1:0] dat_i,
  input  logic [WB_SEL_WIDTH-1:0]  sel_i,
  output logic [WB_DATA_WIDTH-1:0] dat_o,
  output logic                     ack_o,
  output logic                     err_o
);

  localparam int OFS_W = WB_ADDR_WIDTH - 4;  // Below the region nibble

  logic [WB_DATA_WIDTH-1:0] scratch_q [4];
  logic [OFS_W-1:0]         offset;
  logic                     xfer, is_scratch, is_id, bad;

  assign offset     = adr_i[OFS_W-1:0];
  assign xfer       = cyc_i && stb_i;  // No wait states
  assign is_scratch = (offset < OFS_W'('h10));  // 0x0 to 0xC
  assign is_id      = (offset[OFS_W-1:2] == (OFS_W-2)'(4));  // 0x10
  assign bad        = !is_scratch && !(is_id && !we_i);  // ID is read-only

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
      for (int i = 0; i < 4; i++) scratch_q[i] <= '0;
    end else begin
      ack_o <= xfer && !bad;
      err_o <= xfer && bad;
      if (xfer && we_i && is_scratch) begin
        for (int b = 0; b < WB_SEL_WIDTH; b++) begin
          if (sel_i[b]) scratch_q[adr_i[3:2]][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end
    end
  end

  // Read data, registered with the ack
  always_ff @(posedge clk_i) begin
    if (xfer) dat_o <= is_id ? PERIPH_ID : scratch_q[adr_i[3:2]];
  end

endmodule

// ==== wb_bridge_top.sv ====
// Bus bridge subsystem top
module wb_bridge_top import wb_bridge_pkg::*; #(
  parameter int RAM_WORDS = 64
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  logic                     req_rw_i,
  input  logic                     req_uncached_i,
  input  rw_size_e                 req_size_i,
  input  logic [WB_ADDR_WIDTH-1:0] req_addr_i,
  input  logic [BLK_SIZE-1:0]      req_data_i,
  input  logic [ID_WIDTH-1:0]      req_id_i,
  output logic                     res_valid_o,
  output logic                     res_err_o,
  output logic [ID_WIDTH-1:0]      res_id_o,
  output logic [BLK_SIZE-1:0]      res_blk_o
);

  // Master side bus
  logic                     wb_cyc, wb_stb, wb_we;
  logic [WB_ADDR_WIDTH-1:0] wb_adr;
  logic [WB_DATA_WIDTH-1:0] wb_dat_m, wb_dat_s;
  logic [WB_SEL_WIDTH-1:0]  wb_sel;
  logic                     wb_ack, wb_err, wb_stall;
  // Per-slave strobes and replies
  logic                     ram_cyc, ram_stb, ram_ack, ram_stall;
  logic                     periph_cyc, periph_stb, periph_ack, periph_err;
  logic [WB_DATA_WIDTH-1:0] ram_dat, periph_dat;

  wb_master_bridge u_bridge (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_rw_i, .req_uncached_i, .req_size_i,
    .req_addr_i, .req_data_i, .req_id_i,
    .res_valid_o, .res_err_o, .res_id_o, .res_blk_o,
    .wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_we_o (wb_we), .wb_adr_o (wb_adr),
    .wb_dat_o (wb_dat_m), .wb_sel_o (wb_sel),
    .wb_cti_o (),  // Burst tags not used by these slaves
    .wb_bte_o (),
    .wb_dat_i (wb_dat_s), .wb_ack_i (wb_ack), .wb_err_i (wb_err), .wb_stall_i (wb_stall)
  );

  wb_addr_decoder u_decoder (
    .clk_i, .rst_ni, .cyc_i (wb_cyc), .stb_i (wb_stb), .adr_i (wb_adr),
    .ram_cyc_o (ram_cyc), .ram_stb_o (ram_stb), .ram_dat_i (ram_dat),
    .ram_ack_i (ram_ack), .ram_stall_i (ram_stall),
    .periph_cyc_o (periph_cyc), .periph_stb_o (periph_stb), .periph_dat_i (periph_dat),
    .periph_ack_i (periph_ack), .periph_err_i (periph_err),
    .dat_o (wb_dat_s), .ack_o (wb_ack), .err_o (wb_err), .stall_o (wb_stall)
  );

  wb_ram_slave #(.RAM_WORDS(RAM_WORDS)) u_ram (
    .clk_i, .rst_ni, .cyc_i (ram_cyc), .stb_i (ram_stb), .we_i (wb_we), .adr_i (wb_adr),
    .dat_i (wb_dat_m), .sel_i (wb_sel),
    .dat_o (ram_dat), .ack_o (ram_ack), .stall_o (ram_stall)
  );

  wb_periph_slave u_periph (
    .clk_i, .rst_ni, .cyc_i (periph_cyc), .stb_i (periph_stb), .we_i (wb_we),
    .adr_i (wb_adr), .dat_i (wb_dat_m), .sel_i (wb_sel),
    .dat_o (periph_dat), .ack_o (periph_ack), .err_o (periph_err)
  );

endmodule

// ==== tb_wb_bridge.sv ====
// Wishbone bridge regression
module tb_wb_bridge import wb_bridge_pkg::*; ();

  localparam int RAM_WORDS    = 64;
  localparam int IDX_W        = $clog2(RAM_WORDS);
  localparam int RESET_CYCLES = 5;
  localparam int NUM_REQS     = 29;  // Requests issued over all tests
  localparam int LIMIT_CYCLES = NUM_REQS * 40 + RESET_CYCLES;

  logic                     clk_i, rst_ni;
  logic                     req_valid_i, req_ready_o, req_rw_i, req_uncached_i;
  rw_size_e                 req_size_i;
  logic [WB_ADDR_WIDTH-1:0] req_addr_i;
  logic [BLK_SIZE-1:0]      req_data_i, res_blk_o;
  logic [ID_WIDTH-1:0]      req_id_i, res_id_o;
  logic                     res_valid_o, res_err_o;

  logic [31:0]         ram_model [RAM_WORDS];  // Expected RAM contents
  logic [31:0]         scratch_model [4];
  logic [31:0]         lcg_state = 32'hc615;
  logic [ID_WIDTH-1:0] id_ctr = '0;  // Next request ID

  wb_bridge_top #(.RAM_WORDS(RAM_WORDS)) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Watchdog sized from request count
  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

  // ====================
  // Helpers
  // ====================
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [3:0] lane_mask(input rw_size_e size, input logic [1:0] ofs);
    case (size)
      BYTE:    return 4'b0001 << ofs;
      HALF:    return ofs[1] ? 4'b1100 : 4'b0011;  // Pick half by bit 1
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    if (addr[31:28] == 4'h2) return (addr[4]) ? PERIPH_ID : scratch_model[addr[3:2]];
    return ram_model[addr[IDX_W+1:2]];
  endfunction

  task automatic model_store(input logic [31:0] addr, input rw_size_e size,
                             input logic [31:0] word);
    logic [3:0]  mask;
    logic [31:0] cur;
    mask = lane_mask(size, addr[1:0]);
    cur  = model_word(addr);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) cur[8*b +: 8] = word[8*b +: 8];  // Only selected lanes
    end
    if (addr[31:28] == 4'h2) scratch_model[addr[3:2]] = cur;
    else ram_model[addr[IDX_W+1:2]] = cur;
  endtask

  task automatic check_eq(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1, "check failed");
    end
  endtask

  // Issue one request, wait for its single response
  task automatic do_request(input logic rw, input logic unc, input rw_size_e size,
                            input logic [31:0] addr, input logic [127:0] data,
                            output logic err, output logic [127:0] blk);
    logic [ID_WIDTH-1:0] id;
    id     = id_ctr;
    id_ctr = id_ctr + 1'b1;
    @(posedge clk_i);  // Edge right after the previous response
    req_valid_i    <= 1'b1;
    req_rw_i       <= rw;
    req_uncached_i <= unc;
    req_size_i     <= size;
    req_addr_i     <= addr;
    req_data_i     <= data;
    req_id_i       <= id;
    @(negedge clk_i);
    check_eq("res_valid_o", res_valid_o, 1'b0);  // Previous response was one pulse
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);  // Accepted on this edge
    req_valid_i <= 1'b0;
    forever begin
      @(negedge clk_i);
      check_eq("req_ready_o", req_ready_o, 1'b0);  // Port closed while busy
      if (res_valid_o) break;
    end
    err = res_err_o;
    blk = res_blk_o;
    check_eq("res_id_o", res_id_o, id);
  endtask

  task automatic store(input logic unc, input rw_size_e size, input logic [31:0] addr,
                       input logic [31:0] word);
    logic         err;
    logic [127:0] blk;
    do_request(1'b1, unc, size, addr, {96'h0, word}, err, blk);
    check_eq("res_err_o", err, 1'b0);
    check_eq("res_blk_o", blk, '0);  // No data on writes
    model_store(addr, size, word);
  endtask

  task automatic load_check(input logic [31:0] addr);
    logic         err;
    logic [127:0] blk;
    do_request(1'b0, 1'b1, WORD, addr, '0, err, blk);
    check_eq("res_err_o", err, 1'b0);
    check_eq("res_blk_o", blk, {4{model_word(addr)}});  // Word in every lane
  endtask

  task automatic line_write_read(input logic [31:0] base);
    logic         err;
    logic [127:0] line, blk;
    line = {next_rand(), next_rand(), next_rand(), next_rand()};
    do_request(1'b1, 1'b0, WORD, base, line, err, blk);
    check_eq("res_err_o", err, 1'b0);
    for (int i = 0; i < 4; i++) ram_model[base[IDX_W+1:2] + i] = line[32*i +: 32];
    do_request(1'b0, 1'b0, WORD, base, '0, err, blk);
    check_eq("res_err_o", err, 1'b0);
    check_eq("res_blk_o", blk, line);
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic test_line_rw();
    @(negedge clk_i);
    check_eq("req_ready_o", req_ready_o, 1'b1);  // Idle after reset
    check_eq("res_valid_o", res_valid_o, 1'b0);
    line_write_read(32'h0000_0040);
  endtask

  task automatic test_uncached_word();
    store(1'b1, WORD, 32'h0000_0084, next_rand());
    load_check(32'h0000_0084);
    store(1'b1, WORD, 32'h2000_0008, next_rand());  // Scratch 2
    load_check(32'h2000_0008);
  endtask

  task automatic test_subword();
    store(1'b1, WORD, 32'h0000_0100, next_rand());
    for (int b = 0; b < 4; b++) begin
      store(1'b0, BYTE, 32'h0000_0100 + b, next_rand());  // Forced uncached
      load_check(32'h0000_0100);
    end
    store(1'b0, HALF, 32'h0000_0102, next_rand());
    load_check(32'h0000_0100);
    store(1'b0, BYTE, 32'h2000_0005, next_rand());  // Scratch 1, lane 1
    load_check(32'h2000_0004);
  endtask

  task automatic test_id_reg();
    logic         err;
    logic [127:0] blk;
    load_check(32'h2000_0010);
    do_request(1'b1, 1'b1, WORD, 32'h2000_0010, {4{next_rand()}}, err, blk);
    check_eq("res_err_o", err, 1'b1);  // Read-only
    load_check(32'h2000_0010);
  endtask

  task automatic test_unmapped();
    logic         err;
    logic [127:0] blk;
    do_request(1'b0, 1'b1, WORD, 32'h4000_0000, '0, err, blk);
    check_eq("res_err_o", err, 1'b1);
    do_request(1'b0, 1'b0, WORD, 32'h4000_0040, '0, err, blk);  // Burst
    check_eq("res_err_o", err, 1'b1);
    load_check(32'h0000_0084);  // Recovers
  endtask

  task automatic test_back_to_back();
    line_write_read(32'h0000_0080);
    store(1'b1, WORD, 32'h2000_0000, next_rand());
    load_check(32'h2000_0000);
  endtask

  initial begin
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_rw_i       = 1'b0;
    req_uncached_i = 1'b0;
    req_size_i     = WORD;
    req_addr_i     = '0;
    req_data_i     = '0;
    req_id_i       = '0;
    for (int i = 0; i < 4; i++) scratch_model[i] = '0;  // Scratch resets to zero
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_line_rw();
    test_uncached_word();
    test_subword();
    test_id_reg();
    test_unmapped();
    test_back_to_back();
    @(negedge clk_i);
    check_eq("res_valid_o", res_valid_o, 1'b0);  // Last response was one pulse
    check_eq("req_ready_o", req_ready_o, 1'b1);
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== files.f ====
wb_bridge_pkg.sv
wb_master_bridge.sv
wb_addr_decoder.sv
wb_ram_slave.sv
wb_periph_slave.sv
wb_bridge_top.sv
tb_wb_bridge.sv

// ==== Bender.yml ====
package:
  name: wb_bridge

sources:
  - wb_bridge_pkg.sv
  - wb_master_bridge.sv
  - wb_addr_decoder.sv
  - wb_ram_slave.sv
  - wb_periph_slave.sv
  - wb_bridge_top.sv
  - target: test
    files:
      - tb_wb_bridge.sv
